// File: sim.f
+incdir+common
common/usbTxPkg.sv
usbTx/usbTxBitCounter.sv
usbTx/usbTxFsm.sv
verilog/usbCrc16.sv
verilog/usbBitStuffer.sv
verilog/usbNrziLine.sv
verilog/usbTxTop.sv
bench/usbTx_properties.sv
bench/usbTxTb.sv

// File: Bender.yml
package:
  name: usb_tx

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/usbTxPkg.sv
      - usbTx/usbTxBitCounter.sv
      - usbTx/usbTxFsm.sv
      - verilog/usbCrc16.sv
      - verilog/usbBitStuffer.sv
      - verilog/usbNrziLine.sv
      - verilog/usbTxTop.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/usbTx_properties.sv
      - bench/usbTxTb.sv

// File: bench/usbTxTb.sv
`include "usbTx_config.svh"

module usbTxTb;
    timeunit 1ns;
    timeprecision 100ps;
    import usbTxPkg::*;

    logic       clk12_i = 1'b0;
    logic       rstN_i;
    logic       txReqSendPacket_i;
    logic       txDataValid_i;
    txByte_t    txByte_i;
    logic       txAcceptNewData_o;
    logic       sending_o;
    logic       underrun_o;
    lineOut_t   line_o;

    int         errors = 0;
    int         testStartErrors = 0;
    int         testsRun = 0;
    int         testsFailed = 0;
    int         pktSent = 0;
    int         cmpCount = 0;
    int         expLineBits;
    logic       expWithCrc = 1'b0;
    logic [7:0] payload[$];
    logic [7:0] expBytes[$];
    event       pktDecoded;

    logic       prevSending = 1'b0;
    logic       inPkt = 1'b0;
    lineOut_t   level;
    logic       bitVal;
    logic       endJ;
    logic       stuffErr;
    logic [7:0] syncBits;
    logic [7:0] curByte;
    int         nSync;
    int         nBits;
    int         onesRun;
    int         se0Bits;
    int         lineBits;
    logic [7:0] rxBytes[$];

    usbTxTop usbTxTop_inst (
        .clk12_i(clk12_i),
        .rstN_i(rstN_i),
        .txReqSendPacket_i(txReqSendPacket_i),
        .txDataValid_i(txDataValid_i),
        .txByte_i(txByte_i),
        .txAcceptNewData_o(txAcceptNewData_o),
        .sending_o(sending_o),
        .underrun_o(underrun_o),
        .line_o(line_o)
    );

    always #4 clk12_i = ~clk12_i;

    // reflected USB CRC16, complemented.
    function automatic logic [15:0] crc16Ref(input logic [7:0] data[$]);
        logic [15:0] crc;
        crc = `USB_CRC16_SEED;
        foreach (data[i]) begin
            for (int b = 0; b < 8; b++) begin
                if (crc[0] ^ data[i][b]) begin
                    crc = (crc >> 1) ^ 16'hA001;
                end else begin
                    crc = crc >> 1;
                end
            end
        end
        return ~crc;
    endfunction

    function automatic int stuffBitCount(input logic [7:0] data[$]);
        int run;
        int count;
        run = 0;
        count = 0;
        foreach (data[i]) begin
            for (int b = 0; b < 8; b++) begin
                run = data[i][b] ? run + 1 : 0;
                if (run == `USB_STUFF_LIMIT) begin
                    count++;
                    run = 0;
                end
            end
        end
        return count;
    endfunction

    function automatic int totalErrors();
        return errors + usbTxTop_inst.lineChecks.assertFails;
    endfunction

    task automatic checkEq(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("FAIL %0t %s expected %0h got %0h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic abortTimeout(input string what);
        $display("timeout waiting for %s", what);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic waitAccept();
        int n;
        n = 0;
        do begin
            @(negedge clk12_i);
            n++;
        end while (!txAcceptNewData_o && n < 64);
        if (!txAcceptNewData_o) begin
            abortTimeout("accept pulse");
        end
    endtask

    task automatic waitIdle();
        int n;
        n = 0;
        do begin
            @(negedge clk12_i);
            n++;
        end while (sending_o && n < 2000);
        if (sending_o) begin
            abortTimeout("end of packet");
        end
    endtask

    task automatic waitCompare();
        int n;
        n = 0;
        do begin
            @(negedge clk12_i);
            n++;
        end while (cmpCount < pktSent && n < 16);
        if (cmpCount < pktSent) begin
            abortTimeout("decoded packet");
        end
    endtask

    task automatic expectPacket(input logic [7:0] pid, input int nPayload, input logic withCrc);
        logic [15:0] crc;
        expBytes = {pid};
        expWithCrc = withCrc;
        for (int i = 0; i < nPayload; i++) begin
            expBytes.push_back(payload[i]);
        end
        if (withCrc) begin
            crc = crc16Ref(payload);
            expBytes.push_back(crc[7:0]); // low byte first.
            expBytes.push_back(crc[15:8]);
        end
        expLineBits = `USB_SYNC_BITS + 8 * expBytes.size() + stuffBitCount(expBytes)
                      + `USB_EOP_SE0_BITS + 1;
    endtask

    task automatic sendPacket(input logic [7:0] pid, input int stopAt);
        logic [7:0] bytes[$];
        int n;
        bytes = payload;
        bytes.push_front(pid);
        n = bytes.size();
        @(posedge clk12_i);
        #1;
        txByte_i.data = pid;
        txByte_i.isLast = n == 1;
        txDataValid_i = stopAt != 0;
        txReqSendPacket_i = 1'b1;
        @(posedge clk12_i);
        #1;
        txReqSendPacket_i = 1'b0;
        for (int i = 0; i < n; i++) begin
            if (i > 0) begin
                txByte_i.data = bytes[i];
                txByte_i.isLast = i == n - 1;
                txDataValid_i = i != stopAt;
            end
            waitAccept();
            @(posedge clk12_i);
            #1;
            txDataValid_i = 1'b0;
            if (i == stopAt) begin
                break;
            end
        end
        waitIdle();
        pktSent++;
        waitCompare();
    endtask

    task automatic startTest();
        testStartErrors = totalErrors();
    endtask

    task automatic endTest(input string name);
        testsRun++;
        if (totalErrors() == testStartErrors) begin
            $display("test %0d %s: ok", testsRun, name);
        end else begin
            testsFailed++;
            $display("test %0d %s: %0d errors", testsRun, name, totalErrors() - testStartErrors);
        end
    endtask

    // line decoder, one sample per bit while the packet is on the line.
    always @(negedge clk12_i) begin
        if (prevSending) begin
            if (!inPkt) begin
                inPkt = 1'b1;
                level = LINE_J;
                nSync = 0;
                nBits = 0;
                onesRun = 0;
                se0Bits = 0;
                lineBits = 0;
                endJ = 1'b0;
                stuffErr = 1'b0;
                rxBytes = {};
            end
            lineBits++;
            if (line_o == LINE_SE0) begin
                se0Bits++;
            end else if (se0Bits > 0) begin
                endJ = line_o == LINE_J;
            end else begin
                bitVal = line_o == level; // no transition is a one.
                level = line_o;
                if (nSync < `USB_SYNC_BITS) begin
                    syncBits[nSync] = bitVal;
                    nSync++;
                end else if (onesRun == `USB_STUFF_LIMIT) begin
                    stuffErr = stuffErr | bitVal;
                    onesRun = 0;
                end else begin
                    onesRun = bitVal ? onesRun + 1 : 0;
                    curByte[nBits] = bitVal;
                    nBits++;
                    if (nBits == 8) begin
                        rxBytes.push_back(curByte);
                        nBits = 0;
                    end
                end
            end
        end else if (inPkt) begin
            inPkt = 1'b0;
            -> pktDecoded;
        end
        prevSending = sending_o;
    end

    always @(pktDecoded) begin
        logic [7:0]  body[$];
        logic [15:0] rem;
        logic [15:0] remRev;
        checkEq("syncPattern", 8'h80, syncBits);
        checkEq("byteCount", expBytes.size(), rxBytes.size());
        foreach (expBytes[i]) begin
            if (i < rxBytes.size()) begin
                checkEq($sformatf("byte%0d", i), expBytes[i], rxBytes[i]);
            end
        end
        // payload plus CRC leaves the fixed residue in the register.
        if (expWithCrc && rxBytes.size() >= 3) begin
            body = rxBytes[1:$];
            rem = ~crc16Ref(body);
            for (int k = 0; k < 16; k++) begin
                remRev[k] = rem[15 - k];
            end
            checkEq("crcResidue", `USB_CRC16_RESIDUE, remRev);
        end
        checkEq("leftoverBits", 0, nBits);
        checkEq("stuffError", 0, stuffErr);
        checkEq("se0Bits", `USB_EOP_SE0_BITS, se0Bits);
        checkEq("eopJ", 1, endJ);
        checkEq("lineBits", expLineBits, lineBits);
        cmpCount++;
    end

    initial begin
        int len;
        void'($urandom(32'ha593a1e3));
        rstN_i = 1'b0;
        txReqSendPacket_i = 1'b0;
        txDataValid_i = 1'b0;
        txByte_i = '0;
        repeat (16) @(posedge clk12_i);
        #1;
        rstN_i = 1'b1;

        startTest();
        repeat (4) @(negedge clk12_i);
        checkEq("line_o", LINE_J, line_o);
        checkEq("sending_o", 0, sending_o);
        checkEq("txAcceptNewData_o", 0, txAcceptNewData_o);
        checkEq("underrun_o", 0, underrun_o);
        endTest("idle after reset");

        startTest();
        payload = {};
        expectPacket(PID_ACK, 0, 1'b0);
        sendPacket(PID_ACK, -1);
        endTest("ACK handshake");

        startTest();
        for (int p = 0; p < 6; p++) begin
            len = (p == 0) ? 0 : (p == 1) ? 16 : $urandom_range(16, 0);
            payload = {};
            repeat (len) payload.push_back(8'($urandom));
            expectPacket(PID_DATA0, len, 1'b1);
            sendPacket(PID_DATA0, -1);
        end
        endTest("DATA0 random payloads");

        startTest();
        payload = {};
        repeat (16) payload.push_back(8'hFF);
        expectPacket(PID_DATA0, 16, 1'b1);
        sendPacket(PID_DATA0, -1);
        endTest("bit stuffing");

        startTest();
        payload = {8'h11, 8'h22, 8'h33};
        expectPacket(PID_DATA0, 0, 1'b0); // ends after the PID.
        sendPacket(PID_DATA0, 1);
        checkEq("underrun_o", 1, underrun_o);
        payload = {8'h5A, 8'hA5};
        expectPacket(PID_DATA1, 2, 1'b1);
        sendPacket(PID_DATA1, -1);
        checkEq("underrun_o", 0, underrun_o);
        endTest("underrun and recovery");

        $display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, totalErrors());
        if (totalErrors() == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: bench/usbTx_properties.sv
module usbTxProperties (
    input  logic               clk12_i,
    input  logic               rstN_i,
    input  logic               sending_i,
    input  logic               accept_i,
    input  usbTxPkg::lineOut_t line_i
);
    timeunit 1ns;
    timeprecision 100ps;
    import usbTxPkg::*;

    int         assertFails = 0;
    logic       lineActive;
    lineOut_t   prevLine;
    logic [3:0] holdCnt;

    always_ff @(posedge clk12_i or negedge rstN_i) begin
        if (!rstN_i) begin
            lineActive <= 1'b0;
            prevLine   <= LINE_J;
            holdCnt    <= '0;
        end else begin
            lineActive <= sending_i; // line trails sending by one bit.
            prevLine   <= line_i;
            if (lineActive && line_i != LINE_SE0 && line_i == prevLine) begin
                holdCnt <= holdCnt + 4'd1;
            end else begin
                holdCnt <= '0;
            end
        end
    end

    idleIsJ: assert property (@(posedge clk12_i) disable iff (!rstN_i)
        !sending_i |-> line_i == LINE_J)
        else begin
            assertFails++;
            $error("line not in J while not sending");
        end

    noSe1: assert property (@(posedge clk12_i) disable iff (!rstN_i)
        !(line_i.dp && line_i.dn))
        else begin
            assertFails++;
            $error("dp and dn both high");
        end

    // six ones after a transition keep one level for seven bits.
    levelRunLimit: assert property (@(posedge clk12_i) disable iff (!rstN_i)
        holdCnt <= 4'd6)
        else begin
            assertFails++;
            $error("line level held longer than seven bits");
        end

    acceptOneCycle: assert property (@(posedge clk12_i) disable iff (!rstN_i)
        accept_i |=> !accept_i)
        else begin
            assertFails++;
            $error("accept pulse longer than one cycle");
        end

endmodule

bind usbTxTop usbTxProperties lineChecks (
    .clk12_i(clk12_i),
    .rstN_i(rstN_i),
    .sending_i(sending_o),
    .accept_i(txAcceptNewData_o),
    .line_i(line_o)
);

// File: verilog/usbTxTop.sv
module usbTxTop (
    input  logic               clk12_i,
    input  logic               rstN_i,
    input  logic               txReqSendPacket_i,
    input  logic               txDataValid_i,
    input  usbTxPkg::txByte_t  txByte_i,
    output logic               txAcceptNewData_o,
    output logic               sending_o,
    output logic               underrun_o,
    output usbTxPkg::lineOut_t line_o
);
    import usbTxPkg::*;

    txPhase_e    phase;
    bitSlot_t    slot;
    logic        txBit;
    logic        se0;
    logic        stuffEnable;
    logic        stuffedBit;
    logic        stuffStall;
    logic        crcClear;
    logic        crcValid;
    logic        crcBit;
    logic [15:0] crcRem;

    assign stuffEnable = phase inside {PID, DATA, CRC};

    usbTxFsm fsm (
        .clk12_i(clk12_i),
        .rstN_i(rstN_i),
        .txReqSendPacket_i(txReqSendPacket_i),
        .txDataValid_i(txDataValid_i),
        .txByte_i(txByte_i),
        .slot_i(slot),
        .stuffStall_i(stuffStall),
        .crcRem_i(crcRem),
        .txAcceptNewData_o(txAcceptNewData_o),
        .phase_o(phase),
        .txBit_o(txBit),
        .se0_o(se0),
        .sending_o(sending_o),
        .underrun_o(underrun_o),
        .crcClear_o(crcClear),
        .crcValid_o(crcValid),
        .crcBit_o(crcBit)
    );

    usbTxBitCounter bitCounter (
        .clk12_i(clk12_i),
        .rstN_i(rstN_i),
        .phase_i(phase),
        .stuffStall_i(stuffStall),
        .slot_o(slot)
    );

    usbCrc16 crcEngine (
        .clk12_i(clk12_i),
        .rstN_i(rstN_i),
        .clear_i(crcClear),
        .valid_i(crcValid),
        .bit_i(crcBit),
        .crcRem_o(crcRem)
    );

    usbBitStuffer bitStuffer (
        .clk12_i(clk12_i),
        .rstN_i(rstN_i),
        .enable_i(stuffEnable),
        .bit_i(txBit),
        .bit_o(stuffedBit),
        .stuffStall_o(stuffStall)
    );

    usbNrziLine lineDriver (
        .clk12_i(clk12_i),
        .rstN_i(rstN_i),
        .sending_i(sending_o),
        .se0_i(se0),
        .bit_i(stuffedBit),
        .line_o(line_o)
    );

endmodule

// File: verilog/usbNrziLine.sv
module usbNrziLine (
    input  logic               clk12_i,
    input  logic               rstN_i,
    input  logic               sending_i,
    input  logic               se0_i,
    input  logic               bit_i,
    output usbTxPkg::lineOut_t line_o
);
    import usbTxPkg::*;

    logic levelJ;
    logic nextJ;

    // a zero toggles, a one holds.
    assign nextJ = bit_i ? levelJ : !levelJ;

    always_ff @(posedge clk12_i or negedge rstN_i) begin
        if (!rstN_i) begin
            levelJ <= 1'b1;
            line_o <= LINE_J;
        end else if (!sending_i) begin
            levelJ <= 1'b1; // idle, next packet starts from J.
            line_o <= LINE_J;
        end else if (se0_i) begin
            levelJ <= 1'b1; // EOP ends in J.
            line_o <= LINE_SE0;
        end else begin
            levelJ <= nextJ;
            line_o <= nextJ ? LINE_J : LINE_K;
        end
    end

endmodule

// File: verilog/usbBitStuffer.sv
`include "usbTx_config.svh"

module usbBitStuffer (
    input  logic clk12_i,
    input  logic rstN_i,
    input  logic enable_i,
    input  logic bit_i,
    output logic bit_o,
    output logic stuffStall_o
);

    localparam int CW = $clog2(`USB_STUFF_LIMIT + 1);

    logic [CW-1:0] onesCnt;

    // not gated by enable, so a run ending the CRC is stuffed ahead of EOP.
    assign stuffStall_o = onesCnt == CW'(`USB_STUFF_LIMIT);
    assign bit_o        = stuffStall_o ? 1'b0 : bit_i;

    always_ff @(posedge clk12_i or negedge rstN_i) begin
        if (!rstN_i) begin
            onesCnt <= '0;
        end else if (stuffStall_o || !enable_i || !bit_i) begin
            onesCnt <= '0; // a zero went out.
        end else begin
            onesCnt <= onesCnt + CW'(1);
        end
    end

endmodule

// File: verilog/usbCrc16.sv
`include "usbTx_config.svh"

module usbCrc16 (
    input  logic        clk12_i,
    input  logic        rstN_i,
    input  logic        clear_i,
    input  logic        valid_i,
    input  logic        bit_i,
    output logic [15:0] crcRem_o
);

    logic [15:0] crcReg;
    logic        feedback;

    assign feedback = bit_i ^ crcReg[15];

    always_ff @(posedge clk12_i or negedge rstN_i) begin
        if (!rstN_i) begin
            crcReg <= `USB_CRC16_SEED;
        end else if (clear_i) begin
            crcReg <= `USB_CRC16_SEED;
        end else if (valid_i) begin
            crcReg <= {crcReg[14:0], 1'b0} ^ (feedback ? `USB_CRC16_POLY : 16'h0000);
        end
    end

    // bit 15 goes out first on the wire, so it lands in bit 0 here.
    always_comb begin
        for (int i = 0; i < 16; i++) begin
            crcRem_o[i] = ~crcReg[15 - i];
        end
    end

endmodule

// File: usbTx/usbTxFsm.sv
`include "usbTx_config.svh"

module usbTxFsm (
    input  logic                 clk12_i,
    input  logic                 rstN_i,
    input  logic                 txReqSendPacket_i,
    input  logic                 txDataValid_i,
    input  usbTxPkg::txByte_t    txByte_i,
    input  usbTxPkg::bitSlot_t   slot_i,
    input  logic                 stuffStall_i,
    input  logic [15:0]          crcRem_i,
    output logic                 txAcceptNewData_o,
    output usbTxPkg::txPhase_e   phase_o,
    output logic                 txBit_o,
    output logic                 se0_o,
    output logic                 sending_o,
    output logic                 underrun_o,
    output logic                 crcClear_o,
    output logic                 crcValid_o,
    output logic                 crcBit_o
);
    import usbTxPkg::*;

    txPhase_e   phase;
    txPhase_e   phaseNext;
    logic [7:0] shiftReg;
    logic       lastByte;
    logic       dataPid;
    logic       crcHi;
    logic       byteEnd;
    logic       needByte;
    logic       takeByte;

    assign byteEnd = slot_i.lastSlot && slot_i.advance;

    // PID is requested at the start of SYNC, later bytes in the last slot.
    always_comb begin
        case (phase)
            SYNC:      needByte = slot_i.advance && (slot_i.bitIdx == 3'd0);
            PID, DATA: needByte = byteEnd && !lastByte;
            default:   needByte = 1'b0;
        endcase
    end

    assign takeByte = needByte && txDataValid_i;

    always_comb begin
        phaseNext = phase;
        case (phase)
            IDLE: begin
                if (txReqSendPacket_i) begin
                    phaseNext = SYNC;
                end
            end
            SYNC: begin
                if (needByte && !txDataValid_i) begin
                    phaseNext = EOP; // underrun on the PID.
                end else if (byteEnd) begin
                    phaseNext = PID;
                end
            end
            PID, DATA: begin
                if (needByte) begin
                    phaseNext = txDataValid_i ? DATA : EOP;
                end else if (byteEnd) begin
                    phaseNext = dataPid ? CRC : EOP;
                end
            end
            CRC: begin
                if (byteEnd) begin
                    phaseNext = EOP;
                end
            end
            EOP: begin
                if (byteEnd) begin
                    phaseNext = IDLE;
                end
            end
            default: phaseNext = IDLE;
        endcase
    end

    always_ff @(posedge clk12_i or negedge rstN_i) begin
        if (!rstN_i) begin
            phase      <= IDLE;
            underrun_o <= 1'b0;
            lastByte   <= 1'b0;
            dataPid    <= 1'b0;
            crcHi      <= 1'b0;
        end else begin
            phase <= phaseNext;
            if (phase == IDLE && txReqSendPacket_i) begin
                underrun_o <= 1'b0;
            end else if (needByte && !txDataValid_i) begin
                underrun_o <= 1'b1; // sticky until the next request.
            end
            if (takeByte) begin
                lastByte <= txByte_i.isLast;
            end
            if (takeByte && phase == SYNC) begin
                dataPid <= (txByte_i.data == PID_DATA0) || (txByte_i.data == PID_DATA1);
            end
            if (phase != CRC) begin
                crcHi <= 1'b0;
            end else if (slot_i.advance && slot_i.bitIdx == 3'd7) begin
                crcHi <= ~crcHi; // upper CRC byte.
            end
        end
    end

    always_ff @(posedge clk12_i) begin
        if (takeByte) begin
            shiftReg <= txByte_i.data;
        end else if (slot_i.advance && (phase == PID || phase == DATA)) begin
            shiftReg <= {1'b0, shiftReg[7:1]};
        end
    end

    always_comb begin
        txBit_o = 1'b1;
        se0_o   = 1'b0;
        case (phase)
            SYNC:      txBit_o = slot_i.lastSlot; // seven zeros, then a one.
            PID, DATA: txBit_o = shiftReg[0];
            CRC:       txBit_o = crcRem_i[{crcHi, slot_i.bitIdx}];
            EOP:       se0_o = !stuffStall_i && (slot_i.bitIdx < 3'(`USB_EOP_SE0_BITS));
            default:   txBit_o = 1'b1;
        endcase
    end

    assign txAcceptNewData_o = needByte;
    assign phase_o           = phase;
    assign sending_o         = phase != IDLE;
    assign crcClear_o        = phase == SYNC;
    assign crcValid_o        = (phase == DATA) && slot_i.advance;
    assign crcBit_o          = shiftReg[0];

endmodule

// File: usbTx/usbTxBitCounter.sv
`include "usbTx_config.svh"

module usbTxBitCounter (
    input  logic                clk12_i,
    input  logic                rstN_i,
    input  usbTxPkg::txPhase_e  phase_i,
    input  logic                stuffStall_i,
    output usbTxPkg::bitSlot_t  slot_o
);
    import usbTxPkg::*;

    txPhase_e   prevPhase;
    logic [4:0] cnt;
    logic [4:0] curIdx;
    logic [4:0] phaseLen;
    logic       advance;
    logic       lastSlot;

    always_comb begin
        case (phase_i)
            SYNC:    phaseLen = 5'(`USB_SYNC_BITS);
            CRC:     phaseLen = 5'd16;
            EOP:     phaseLen = 5'(`USB_EOP_SE0_BITS + 1);
            default: phaseLen = 5'd8;
        endcase
    end

    // a new phase always starts at slot zero.
    assign curIdx   = (phase_i != prevPhase) ? 5'd0 : cnt;
    assign advance  = (phase_i != IDLE) && !stuffStall_i;
    assign lastSlot = curIdx == (phaseLen - 5'd1);

    always_ff @(posedge clk12_i or negedge rstN_i) begin
        if (!rstN_i) begin
            prevPhase <= IDLE;
            cnt       <= '0;
        end else begin
            prevPhase <= phase_i;
            if (phase_i == IDLE || (advance && lastSlot)) begin
                cnt <= '0;
            end else if (advance) begin
                cnt <= curIdx + 5'd1;
            end else begin
                cnt <= curIdx; // frozen on stuff bit.
            end
        end
    end

    assign slot_o.bitIdx   = curIdx[2:0];
    assign slot_o.lastSlot = lastSlot;
    assign slot_o.advance  = advance;

endmodule

// File: common/usbTxPkg.sv
package usbTxPkg;

    // packet phases in transmit order.
    typedef enum logic [2:0] {
        IDLE,
        SYNC,
        PID,
        DATA,
        CRC,
        EOP
    } txPhase_e;

    // byte offered by the source.
    typedef struct packed {
        logic       isLast;
        logic [7:0] data;
    } txByte_t;

    // USB full-speed line pair.
    typedef struct packed {
        logic dp;
        logic dn;
    } lineOut_t;

    // slot report from the bit counter to the FSM.
    typedef struct packed {
        logic [2:0] bitIdx;
        logic       lastSlot;
        logic       advance;
    } bitSlot_t;

    // PID bytes as they sit in the shift register, sent LSB first.
    localparam logic [7:0] PID_DATA0 = 8'hC3;
    localparam logic [7:0] PID_DATA1 = 8'h4B;
    localparam logic [7:0] PID_ACK   = 8'hD2;

    // full-speed line states.
    localparam lineOut_t LINE_J   = 2'b10;
    localparam lineOut_t LINE_K   = 2'b01;
    localparam lineOut_t LINE_SE0 = 2'b00;

endpackage

// File: common/usbTx_config.svh
`ifndef USBTX_CONFIG_SVH
`define USBTX_CONFIG_SVH

// SYNC is KJKJKJKK on full speed.
`define USB_SYNC_BITS 8

// EOP is this many SE0 bits, then one J.
`define USB_EOP_SE0_BITS 2

// ones before a stuff zero.
`define USB_STUFF_LIMIT 6

// x16 + x15 + x2 + 1.
`define USB_CRC16_POLY 16'h8005
`define USB_CRC16_SEED 16'hFFFF
`define USB_CRC16_RESIDUE 16'h800D

`endif
